// ==== common/rt_core_pkg.sv ====
// Sizes are fixed here for a 4-lane 32-bit core; the fetch space is 4096 words, word addressed
package rt_core_pkg;

	// Datapath sizes
	localparam int word_width = 32;
	localparam int lanes = 4;
	localparam int vector_width = lanes * word_width;

	// Register files
	localparam int scalar_regs = 32;
	localparam int vector_regs = 16;
	localparam int scalar_addr_width = $clog2(scalar_regs);
	localparam int vector_addr_width = $clog2(vector_regs);

	// Instruction queue
	localparam int queue_depth = 4;
	localparam int queue_ptr_width = $clog2(queue_depth);
	localparam int queue_count_width = queue_ptr_width + 1;

	// Instruction bus word address
	localparam int addr_width = 12;

	// Instruction field widths
	localparam int opcode_width = 4;
	localparam int imm_width = word_width - opcode_width - 3 * scalar_addr_width;
	localparam int vector_pad_width =
		word_width - opcode_width - 3 * vector_addr_width - scalar_addr_width;

	typedef enum logic [opcode_width-1:0] {
		op_nop     = 4'd0,
		op_addi    = 4'd1,
		op_add     = 4'd2,
		op_sub     = 4'd3,
		op_xor     = 4'd4,
		op_vadd    = 4'd5,
		op_vmul    = 4'd6,
		op_vsplat  = 4'd7,
		op_vreduce = 4'd8,
		op_ctxsw   = 4'd9,
		op_halt    = 4'd10
	} opcode_e;

	typedef struct packed {
		opcode_e                      opcode;
		logic [scalar_addr_width-1:0] rd;
		logic [scalar_addr_width-1:0] rs1;
		logic [scalar_addr_width-1:0] rs2;
		logic [imm_width-1:0]         imm;
	} scalar_fmt_t;

	// rs is the VSPLAT source or the VREDUCE destination
	typedef struct packed {
		opcode_e                      opcode;
		logic [vector_addr_width-1:0] vd;
		logic [vector_addr_width-1:0] vs1;
		logic [vector_addr_width-1:0] vs2;
		logic [scalar_addr_width-1:0] rs;
		logic [vector_pad_width-1:0]  unused;
	} vector_fmt_t;

	// Opcode lands in the same top bits in both views
	typedef union packed {
		scalar_fmt_t scalar;
		vector_fmt_t vector;
	} instr_u;

	typedef struct packed {
		logic                         wen;
		logic [scalar_addr_width-1:0] addr;
		logic [word_width-1:0]        data;
	} scalar_wb_t;

	typedef struct packed {
		logic                         wen;
		logic [vector_addr_width-1:0] addr;
		logic [vector_width-1:0]      data;
	} vector_wb_t;

endpackage

// ==== rt_core/fetch_unit.sv ====
// Read-only Wishbone classic master; one word per bus cycle, never more than one in flight
`timescale 1ns/100ps

module fetch_unit
	import rt_core_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stop,
	input  logic                  full,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output logic [addr_width-1:0] wb_adr,
	input  logic [word_width-1:0] wb_dat,
	input  logic                  wb_ack,
	output logic                  push,
	output instr_u                push_data
);

	typedef enum logic {
		st_idle,
		st_cycle
	} fetch_state_e;

	fetch_state_e state;
	logic [addr_width-1:0] pc;
	logic start;
	logic done;

	// Queue full already reserves room for the word of a new cycle
	assign start = (state == st_idle) && !stop && !full;
	assign done = (state == st_cycle) && wb_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			pc <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start)
						state <= st_cycle;
				end
				st_cycle: begin
					// Cycle in progress finishes even after stop
					if (wb_ack) begin
						state <= st_idle;
						pc <= pc + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Strobe and address held steady until ack
	assign wb_cyc = (state == st_cycle);
	assign wb_stb = (state == st_cycle);
	assign wb_adr = pc;

	// Acked word goes straight into the queue
	assign push = done;
	assign push_data = wb_dat;

endmodule

// ==== rt_core/instr_queue.sv ====
// Circular FIFO; full is raised one entry early, a push into a truly full queue is not guarded
`timescale 1ns/100ps

module instr_queue
	import rt_core_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   push,
	input  instr_u push_data,
	output logic   full,
	output logic   valid,
	output instr_u head,
	input  logic   pop
);

	instr_u mem [queue_depth];
	logic [queue_ptr_width-1:0] wr_ptr;
	logic [queue_ptr_width-1:0] rd_ptr;
	logic [queue_count_width-1:0] count;
	logic do_pop;

	assign do_pop = pop && valid;

	// Entry storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !push)
				count <= count - 1'b1;
		end
	end

	// One-word margin for the word a new bus cycle would bring
	assign full = (int'(count) + 1 >= queue_depth);
	assign valid = (count != '0);
	assign head = mem[rd_ptr];

endmodule

// ==== rt_core/execute_unit.sv ====
// Single-cycle execute; results retire one cycle after the pop, HALT stays in force until reset
`timescale 1ns/100ps

module execute_unit
	import rt_core_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         kernel_mode,
	input  logic                         valid,
	input  instr_u                       head,
	output logic                         pop,
	output logic [scalar_addr_width-1:0] scalar_raddr1,
	output logic [scalar_addr_width-1:0] scalar_raddr2,
	input  logic [word_width-1:0]        scalar_rdata1,
	input  logic [word_width-1:0]        scalar_rdata2,
	output logic [vector_addr_width-1:0] vector_raddr1,
	output logic [vector_addr_width-1:0] vector_raddr2,
	input  logic [vector_width-1:0]      vector_rdata1,
	input  logic [vector_width-1:0]      vector_rdata2,
	output scalar_wb_t                   scalar_wb,
	output vector_wb_t                   vector_wb,
	output logic                         context_switch,
	output logic                         end_program,
	output logic                         stop
);

	opcode_e op;
	logic halted;
	logic ctx_next;
	logic [word_width-1:0] imm_ext;
	logic [word_width-1:0] lane_sum;
	scalar_wb_t scalar_next;
	vector_wb_t vector_next;

	assign op = head.scalar.opcode;
	assign pop = valid && !halted;

	// VSPLAT takes its scalar from the vector view
	assign scalar_raddr1 = (op == op_vsplat) ? head.vector.rs : head.scalar.rs1;
	assign scalar_raddr2 = head.scalar.rs2;
	assign vector_raddr1 = head.vector.vs1;
	assign vector_raddr2 = head.vector.vs2;

	assign imm_ext = {{(word_width - imm_width){head.scalar.imm[imm_width-1]}}, head.scalar.imm};

	always_comb begin
		scalar_next = '0;
		vector_next = '0;
		lane_sum = '0;
		case (op)
			op_addi: begin
				scalar_next.wen = 1'b1;
				scalar_next.addr = head.scalar.rd;
				scalar_next.data = scalar_rdata1 + imm_ext;
			end
			op_add: begin
				scalar_next.wen = 1'b1;
				scalar_next.addr = head.scalar.rd;
				scalar_next.data = scalar_rdata1 + scalar_rdata2;
			end
			op_sub: begin
				scalar_next.wen = 1'b1;
				scalar_next.addr = head.scalar.rd;
				scalar_next.data = scalar_rdata1 - scalar_rdata2;
			end
			op_xor: begin
				scalar_next.wen = 1'b1;
				scalar_next.addr = head.scalar.rd;
				scalar_next.data = scalar_rdata1 ^ scalar_rdata2;
			end
			op_vadd: begin
				vector_next.wen = 1'b1;
				vector_next.addr = head.vector.vd;
				for (int i = 0; i < lanes; i++)
					vector_next.data[i*word_width +: word_width] =
						vector_rdata1[i*word_width +: word_width] +
						vector_rdata2[i*word_width +: word_width];
			end
			op_vmul: begin
				// Low half of each lane product
				vector_next.wen = 1'b1;
				vector_next.addr = head.vector.vd;
				for (int i = 0; i < lanes; i++)
					vector_next.data[i*word_width +: word_width] =
						vector_rdata1[i*word_width +: word_width] *
						vector_rdata2[i*word_width +: word_width];
			end
			op_vsplat: begin
				vector_next.wen = 1'b1;
				vector_next.addr = head.vector.vd;
				vector_next.data = {lanes{scalar_rdata1}};
			end
			op_vreduce: begin
				for (int i = 0; i < lanes; i++)
					lane_sum = lane_sum + vector_rdata1[i*word_width +: word_width];
				scalar_next.wen = 1'b1;
				scalar_next.addr = head.vector.rs;
				scalar_next.data = lane_sum;
			end
			default: begin
			end
		endcase
		// Nothing retires without a pop; r0 is never written
		if (!pop || scalar_next.addr == '0)
			scalar_next.wen = 1'b0;
		if (!pop)
			vector_next.wen = 1'b0;
	end

	assign ctx_next = pop && (op == op_ctxsw) && kernel_mode;

	always_ff @(posedge clk) begin
		if (reset) begin
			scalar_wb.wen <= 1'b0;
			vector_wb.wen <= 1'b0;
			context_switch <= 1'b0;
			halted <= 1'b0;
		end else begin
			scalar_wb <= scalar_next;
			vector_wb <= vector_next;
			context_switch <= ctx_next;
			if (pop && op == op_halt)
				halted <= 1'b1;
		end
	end

	// Sticky halt ends the program and freezes fetch
	assign end_program = halted;
	assign stop = halted;

endmodule

// ==== rt_core/register_files.sv ====
// Combinational reads, writes land on the edge after wen; r0 reads zero whatever is stored
`timescale 1ns/100ps

module register_files
	import rt_core_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic [scalar_addr_width-1:0] scalar_raddr1,
	output logic [word_width-1:0]        scalar_rdata1,
	input  logic [scalar_addr_width-1:0] scalar_raddr2,
	output logic [word_width-1:0]        scalar_rdata2,
	input  logic [vector_addr_width-1:0] vector_raddr1,
	output logic [vector_width-1:0]      vector_rdata1,
	input  logic [vector_addr_width-1:0] vector_raddr2,
	output logic [vector_width-1:0]      vector_rdata2,
	input  scalar_wb_t                   scalar_wb,
	input  vector_wb_t                   vector_wb
);

	logic [word_width-1:0] scalar_mem [scalar_regs];
	logic [vector_width-1:0] vector_mem [vector_regs];

	// Scalar array
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < scalar_regs; i++)
				scalar_mem[i] <= '0;
		end else if (scalar_wb.wen) begin
			scalar_mem[scalar_wb.addr] <= scalar_wb.data;
		end
	end

	// Vector array
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < vector_regs; i++)
				vector_mem[i] <= '0;
		end else if (vector_wb.wen) begin
			vector_mem[vector_wb.addr] <= vector_wb.data;
		end
	end

	assign scalar_rdata1 = (scalar_raddr1 == '0) ? '0 : scalar_mem[scalar_raddr1];
	assign scalar_rdata2 = (scalar_raddr2 == '0) ? '0 : scalar_mem[scalar_raddr2];
	assign vector_rdata1 = vector_mem[vector_raddr1];
	assign vector_rdata2 = vector_mem[vector_raddr2];

endmodule

// ==== hdl/rt_core.sv ====
// Core top; no data memory or branches, writebacks are exposed for retirement checks
`timescale 1ns/100ps

module rt_core
	import rt_core_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  kernel_mode,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output logic [addr_width-1:0] wb_adr,
	input  logic [word_width-1:0] wb_dat,
	input  logic                  wb_ack,
	output scalar_wb_t            scalar_wb,
	output vector_wb_t            vector_wb,
	output logic                  context_switch,
	output logic                  end_program
);

	logic push;
	instr_u push_data;
	logic queue_full;
	logic queue_valid;
	instr_u head;
	logic pop;
	logic stop;
	logic [scalar_addr_width-1:0] scalar_raddr1;
	logic [scalar_addr_width-1:0] scalar_raddr2;
	logic [word_width-1:0] scalar_rdata1;
	logic [word_width-1:0] scalar_rdata2;
	logic [vector_addr_width-1:0] vector_raddr1;
	logic [vector_addr_width-1:0] vector_raddr2;
	logic [vector_width-1:0] vector_rdata1;
	logic [vector_width-1:0] vector_rdata2;

	fetch_unit fetch_unit_inst (
		.clk(clk),
		.reset(reset),
		.stop(stop),
		.full(queue_full),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.push(push),
		.push_data(push_data)
	);

	instr_queue instr_queue_inst (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_data(push_data),
		.full(queue_full),
		.valid(queue_valid),
		.head(head),
		.pop(pop)
	);

	execute_unit execute_unit_inst (
		.clk(clk),
		.reset(reset),
		.kernel_mode(kernel_mode),
		.valid(queue_valid),
		.head(head),
		.pop(pop),
		.scalar_raddr1(scalar_raddr1),
		.scalar_raddr2(scalar_raddr2),
		.scalar_rdata1(scalar_rdata1),
		.scalar_rdata2(scalar_rdata2),
		.vector_raddr1(vector_raddr1),
		.vector_raddr2(vector_raddr2),
		.vector_rdata1(vector_rdata1),
		.vector_rdata2(vector_rdata2),
		.scalar_wb(scalar_wb),
		.vector_wb(vector_wb),
		.context_switch(context_switch),
		.end_program(end_program),
		.stop(stop)
	);

	register_files register_files_inst (
		.clk(clk),
		.reset(reset),
		.scalar_raddr1(scalar_raddr1),
		.scalar_rdata1(scalar_rdata1),
		.scalar_raddr2(scalar_raddr2),
		.scalar_rdata2(scalar_rdata2),
		.vector_raddr1(vector_raddr1),
		.vector_rdata1(vector_rdata1),
		.vector_raddr2(vector_raddr2),
		.vector_rdata2(vector_rdata2),
		.scalar_wb(scalar_wb),
		.vector_wb(vector_wb)
	);

endmodule

// ==== tests/rt_core_asserts.sv ====
// Port-level checks bound into rt_core; all properties are off while reset is high
`timescale 1ns/100ps

module rt_core_asserts
	import rt_core_pkg::*;
(
	input logic                  clk,
	input logic                  reset,
	input logic                  kernel_mode,
	input logic                  wb_cyc,
	input logic                  wb_stb,
	input logic [addr_width-1:0] wb_adr,
	input logic                  wb_ack,
	input scalar_wb_t            scalar_wb,
	input vector_wb_t            vector_wb,
	input logic                  context_switch,
	input logic                  end_program
);

	stb_in_cycle: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
		else $error("wb_stb high outside a bus cycle");

	// Request held until the slave acks
	adr_held: assert property (@(posedge clk) disable iff (reset)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
		else $error("wb_adr or wb_stb changed before ack");

	quiet_after_end: assert property (@(posedge clk) disable iff (reset)
		end_program |-> !scalar_wb.wen && !vector_wb.wen && !context_switch)
		else $error("Result retired after end_program");

	ctx_in_kernel: assert property (@(posedge clk) disable iff (reset)
		context_switch |-> $past(kernel_mode))
		else $error("context_switch without kernel_mode in the retiring cycle");

endmodule

// ==== tests/rt_core_tb.sv ====
// Random 200-word program; fetch must run sequentially from word 0, results are checked in order
`timescale 1ns/100ps

module rt_core_tb
	import rt_core_pkg::*;
();

	localparam int clk_period = 8;
	localparam int reset_cycles = 8;
	localparam int drive_delay = 1;
	localparam int prog_len = 200;
	localparam int drain_cycles = 8;
	localparam int timeout_ns = (prog_len * 5 + reset_cycles + drain_cycles) * clk_period;
	localparam int mem_words = 1 << addr_width;

	typedef enum logic [1:0] {
		ev_none,
		ev_scalar,
		ev_vector,
		ev_ctx
	} event_kind_e;

	// One expected retirement result
	typedef struct packed {
		event_kind_e                  kind;
		logic [scalar_addr_width-1:0] addr;
		logic [vector_width-1:0]      data;
	} wb_event_t;

	logic clk;
	logic reset;
	logic kernel_mode;
	logic wb_cyc;
	logic wb_stb;
	logic [addr_width-1:0] wb_adr;
	logic [word_width-1:0] wb_dat;
	logic wb_ack;
	scalar_wb_t scalar_wb;
	vector_wb_t vector_wb;
	logic context_switch;
	logic end_program;

	logic [word_width-1:0] program_mem [mem_words];
	logic [word_width-1:0] model_sregs [scalar_regs];
	logic [vector_width-1:0] model_vregs [vector_regs];
	logic model_halted;
	logic [addr_width-1:0] retire_pc;
	wb_event_t expected_q [$];
	integer seed = 32'h792f_129e;

	rt_core rt_core_inst (
		.clk(clk),
		.reset(reset),
		.kernel_mode(kernel_mode),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.scalar_wb(scalar_wb),
		.vector_wb(vector_wb),
		.context_switch(context_switch),
		.end_program(end_program)
	);

	bind rt_core rt_core_asserts rt_core_asserts_inst (
		.clk(clk),
		.reset(reset),
		.kernel_mode(kernel_mode),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_ack(wb_ack),
		.scalar_wb(scalar_wb),
		.vector_wb(vector_wb),
		.context_switch(context_switch),
		.end_program(end_program)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected)
			abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	// Applies one instruction to the model registers and returns what should retire
	function automatic wb_event_t reference_step(input logic [31:0] word, input logic kmode);
		wb_event_t ev;
		opcode_e opc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [127:0] va;
		logic [127:0] vb;
		logic [127:0] vr;
		opc = opcode_e'(word[31:28]);
		a = model_sregs[word[22:18]];
		b = model_sregs[word[17:13]];
		imm = {{19{word[12]}}, word[12:0]};
		va = model_vregs[word[23:20]];
		vb = model_vregs[word[19:16]];
		ev = '0;
		res = '0;
		vr = '0;
		case (opc)
			op_addi, op_add, op_sub, op_xor: begin
				case (opc)
					op_addi: res = a + imm;
					op_add: res = a + b;
					op_sub: res = a - b;
					default: res = a ^ b;
				endcase
				ev.addr = word[27:23];
			end
			op_vadd, op_vmul, op_vsplat: begin
				for (int i = 0; i < 4; i++) begin
					if (opc == op_vadd)
						vr[i*32 +: 32] = va[i*32 +: 32] + vb[i*32 +: 32];
					else if (opc == op_vmul)
						vr[i*32 +: 32] = va[i*32 +: 32] * vb[i*32 +: 32];
					else
						vr[i*32 +: 32] = model_sregs[word[15:11]];
				end
				model_vregs[word[27:24]] = vr;
				ev.kind = ev_vector;
				ev.addr = {1'b0, word[27:24]};
				ev.data = vr;
			end
			op_vreduce: begin
				for (int i = 0; i < 4; i++)
					res = res + va[i*32 +: 32];
				ev.addr = word[15:11];
			end
			op_ctxsw: if (kmode) ev.kind = ev_ctx;
			op_halt: model_halted = 1'b1;
			default: begin
			end
		endcase
		// Scalar results land only in r1 to r31
		if (ev.kind == ev_none && ev.addr != '0) begin
			model_sregs[ev.addr] = res;
			ev.kind = ev_scalar;
			ev.data = 128'(res);
		end
		return ev;
	endfunction

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		kernel_mode = 1'b0;
		forever begin
			repeat (50) @(posedge clk);
			#(drive_delay) kernel_mode = ~kernel_mode;
		end
	end

	// Wishbone slave with 0 to 3 wait states per strobe
	initial begin
		int wait_left;
		logic waiting;
		wb_ack = 1'b0;
		wb_dat = '0;
		waiting = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge clk);
			#(drive_delay);
			if (wb_ack) begin
				wb_ack = 1'b0;
				waiting = 1'b0;
			end else if (wb_cyc && wb_stb && !reset) begin
				if (!waiting) begin
					waiting = 1'b1;
					wait_left = $unsigned($random(seed)) % 4;
				end
				if (wait_left == 0) begin
					wb_dat = program_mem[wb_adr];
					wb_ack = 1'b1;
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	// Outputs are stable at the falling edge; pop tells which instruction retires next
	always @(negedge clk) begin : compare_results
		wb_event_t ev;
		event_kind_e seen;
		if (!reset) begin
			if (scalar_wb.wen || vector_wb.wen || context_switch) begin
				if (int'(scalar_wb.wen) + int'(vector_wb.wen) + int'(context_switch) > 1)
					abort_run("More than one result retired in the same cycle");
				if (end_program)
					abort_run("A result retired after end_program was raised");
				if (expected_q.size() == 0)
					abort_run("A result retired when none was expected");
				ev = expected_q.pop_front();
				seen = scalar_wb.wen ? ev_scalar : (vector_wb.wen ? ev_vector : ev_ctx);
				check_value("result kind", 128'(seen), 128'(ev.kind));
				if (seen == ev_scalar) begin
					check_value("scalar_wb.addr", 128'(scalar_wb.addr), 128'(ev.addr));
					check_value("scalar_wb.data", 128'(scalar_wb.data), ev.data);
				end else if (seen == ev_vector) begin
					check_value("vector_wb.addr", 128'(vector_wb.addr), 128'(ev.addr));
					check_value("vector_wb.data", vector_wb.data, ev.data);
				end
			end
			if (rt_core_inst.pop) begin
				if (model_halted)
					abort_run("An instruction retired after HALT");
				ev = reference_step(program_mem[retire_pc], kernel_mode);
				retire_pc = retire_pc + 1'b1;
				if (ev.kind != ev_none)
					expected_q.push_back(ev);
			end
		end
	end

	initial begin
		#(timeout_ns);
		abort_run("Timeout: the program did not reach HALT in the time allowed");
	end

	initial begin
		logic [word_width-1:0] word;
		reset = 1'b1;
		model_sregs = '{default: '0};
		model_vregs = '{default: '0};
		model_halted = 1'b0;
		retire_pc = '0;
		// Past the program end, NOP words carry their address in the low bits
		for (int i = 0; i < mem_words; i++) begin
			word = 32'(i);
			if (i < prog_len) begin
				word = $random(seed);
				if (i == prog_len - 1)
					word[31:28] = op_halt;
				else if (i % 20 == 19)
					word[31:28] = op_ctxsw;
				else
					word[31:28] = 4'($unsigned($random(seed)) % 9);
			end
			program_mem[addr_width'(i)] = word;
		end
		repeat (reset_cycles) @(posedge clk);
		#(drive_delay) reset = 1'b0;
		while (!end_program)
			@(negedge clk);
		repeat (drain_cycles) @(negedge clk);
		check_value("end_program", 128'(end_program), 128'(1));
		check_value("retired words", 128'(retire_pc), 128'(prog_len));
		check_value("pending results", 128'(expected_q.size()), 128'(0));
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== compile.f ====
common/rt_core_pkg.sv
rt_core/fetch_unit.sv
rt_core/instr_queue.sv
rt_core/execute_unit.sv
rt_core/register_files.sv
hdl/rt_core.sv
tests/rt_core_asserts.sv
tests/rt_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module rt_core_tb \
	-f compile.f \
	--Mdir obj_dir -o rt_core_sim

./obj_dir/rt_core_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
	echo "Simulation ended without a pass result"
	exit 1
fi

echo "Simulation passed"
